/* tb.f */
+incdir+.
f9mg_pkg.sv
f9mg_cmd_buffer.sv
f9mg_resn_store.sv
f9mg_local_cmd.sv
f9mg_recover_fifo.sv
f9mg_cmd_top.sv
tb_f9mg_cmd_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the f9mg command decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_f9mg_cmd_top \
  -f tb.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* tb_f9mg_cmd_top.sv */
`include "f9mg_params.svh"

module tb_f9mg_cmd_top;

  import f9mg_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 14;
  localparam int MSG_MAX    = 160;
  localparam int MSG_W      = MSG_MAX * 8;
  localparam int SETTLE     = 5;

  logic                        axis_clk_in;
  logic                        axis_rst_in;
  logic                        axis_valid_in;
  logic                        axis_ready_in;
  logic [`F9MG_DATA_WIDTH-1:0] axis_data_in;
  logic [`F9MG_KEEP_WIDTH-1:0] axis_keep_in;
  logic                        axis_last_in;
  logic                        rcvr_pop;
  logic                        f9pcap_en;
  sn_record_t                  sn_rec;
  logic [`F9MG_SGAP_WIDTH-1:0] sgap;
  logic                        rcvr_valid;
  rcvr_req_t                   rcvr_data;

  // message table with bytes left aligned so the first byte sits at the top
  string                       test_name [NUM_TESTS];
  logic [MSG_W-1:0]            msg_data  [NUM_TESTS];
  int                          msg_len   [NUM_TESTS];
  bit                          msg_gaps  [NUM_TESTS];
  sn_record_t                  exp_rec   [NUM_TESTS];
  logic                        exp_en    [NUM_TESTS];
  logic [`F9MG_SGAP_WIDTH-1:0] exp_gap   [NUM_TESTS];
  bit                          exp_push  [NUM_TESTS];
  rcvr_req_t                   exp_req   [NUM_TESTS];
  bit                          drain     [NUM_TESTS];

  // requests expected in the recover queue with the oldest first
  rcvr_req_t pending [$];
  int        err_count;
  int        fail_tests;
  int        num_filled;

  f9mg_cmd_top f9mg_cmd_top_i (
    .axis_clk_in   (axis_clk_in),
    .axis_rst_in   (axis_rst_in),
    .axis_valid_in (axis_valid_in),
    .axis_ready_in (axis_ready_in),
    .axis_data_in  (axis_data_in),
    .axis_keep_in  (axis_keep_in),
    .axis_last_in  (axis_last_in),
    .rcvr_pop      (rcvr_pop),
    .f9pcap_en     (f9pcap_en),
    .sn_rec        (sn_rec),
    .sgap          (sgap),
    .rcvr_valid    (rcvr_valid),
    .rcvr_data     (rcvr_data)
  );

  initial begin
    axis_clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) axis_clk_in = ~axis_clk_in;
  end

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("timeout: the message table did not finish in %0d cycles", NUM_TESTS * 200);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_rec(input sn_record_t exp, input sn_record_t act);
    if (act !== exp) begin
      $display("Fail sn_rec: expected 0x%h got 0x%h", exp, act);
      err_count++;
    end
  endtask

  task automatic check_gap(input logic [`F9MG_SGAP_WIDTH-1:0] exp,
                           input logic [`F9MG_SGAP_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("Fail sgap: expected 0x%h got 0x%h", exp, act);
      err_count++;
    end
  endtask

  task automatic check_rcvr(input rcvr_req_t exp, input rcvr_req_t act);
    if (act !== exp) begin
      $display("Fail rcvr_data: expected 0x%h got 0x%h", exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(input string sig, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h got 0x%h", sig, exp, act);
      err_count++;
    end
  endtask

  // --------------------------------------------------------------------------
  // table construction
  // --------------------------------------------------------------------------
  task automatic add_test(input string name, input logic [MSG_W-1:0] raw, input int len,
                          input bit gaps, input sn_record_t rec, input logic en,
                          input logic [`F9MG_SGAP_WIDTH-1:0] gap, input bit push,
                          input rcvr_req_t req, input bit drn);
    test_name[num_filled] = name;
    msg_data[num_filled]  = raw << (8 * (MSG_MAX - len));
    msg_len[num_filled]   = len;
    msg_gaps[num_filled]  = gaps;
    exp_rec[num_filled]   = rec;
    exp_en[num_filled]    = en;
    exp_gap[num_filled]   = gap;
    exp_push[num_filled]  = push;
    exp_req[num_filled]   = req;
    drain[num_filled]     = drn;
    num_filled++;
  endtask

  task automatic build_table();
    sn_record_t rec_a;
    sn_record_t rec_b;
    sn_record_t rec_c;
    rec_a = '{dev_name: DEV_NAME, sn: 64'h0011_2233_4455_6677, mcgroup_addr: 32'hEF01_0203,
              mcgroup_port: 16'h1F90, src_mac_addr: 48'h0200_AABB_CCDD,
              src_ip_addr: 32'hC0A8_0A05, src_port: 16'hD431};
    rec_b = '{dev_name: DEV_NAME, sn: 64'h8899_AABB_CCDD_EEFF, mcgroup_addr: 32'hEF10_2030,
              mcgroup_port: 16'h2710, src_mac_addr: 48'h0211_2233_4455,
              src_ip_addr: 32'h0A00_0001, src_port: 16'h1388};
    rec_c = rec_b;
    rec_c.dev_name = "other1";
    // global command
    add_test("resn_f9pcap", MSG_W'({CMD_RESN, rec_a}), 44, 0, rec_a, 1, '0, 0, '0, 0);
    add_test("resn_long", MSG_W'({CMD_RESN, rec_b, 8'h00}), 45, 0, rec_a, 1, '0, 0, '0, 0);
    add_test("resn_bad_cmd", MSG_W'({"fonwin:resx:", rec_b}), 44, 0, rec_a, 1, '0, 0, '0, 0);
    add_test("resn_other_name", MSG_W'({CMD_RESN, rec_c}), 44, 0, rec_c, 0, '0, 0, '0, 0);
    add_test("resn_gapped", MSG_W'({CMD_RESN, rec_a}), 44, 1, rec_a, 1, '0, 0, '0, 0);
    // sgap
    add_test("sgap_match", MSG_W'({rec_a.sn, LCMD_SGAP, DEV_NAME, 32'h1234_5678}), 22, 0,
             rec_a, 1, 32'h1234_5678, 0, '0, 0);
    add_test("sgap_bad_sn", MSG_W'({rec_b.sn, LCMD_SGAP, DEV_NAME, 32'h0BAD_0BAD}), 22, 0,
             rec_a, 1, 32'h1234_5678, 0, '0, 0);
    add_test("sgap_bad_len", MSG_W'({rec_a.sn, LCMD_SGAP, DEV_NAME, 40'h99_8877_6655}), 23, 0,
             rec_a, 1, 32'h1234_5678, 0, '0, 0);
    // rcvr requests are drained in order after the third
    add_test("rcvr_first", MSG_W'({rec_a.sn, LCMD_RCVR, DEV_NAME, 64'h0101_0202_0303_0404}),
             26, 0, rec_a, 1, 32'h1234_5678, 1, 64'h0101_0202_0303_0404, 0);
    add_test("rcvr_second", MSG_W'({rec_a.sn, LCMD_RCVR, DEV_NAME, 64'hA5A5_0000_FFFF_1234}),
             26, 1, rec_a, 1, 32'h1234_5678, 1, 64'hA5A5_0000_FFFF_1234, 0);
    add_test("rcvr_third", MSG_W'({rec_a.sn, LCMD_RCVR, DEV_NAME, 64'hDEAD_BEEF_0BAD_F00D}),
             26, 0, rec_a, 1, 32'h1234_5678, 1, 64'hDEAD_BEEF_0BAD_F00D, 1);
    add_test("rcvr_bad_len", MSG_W'({rec_a.sn, LCMD_RCVR, DEV_NAME, 56'h11_2233_4455_6677}),
             25, 0, rec_a, 1, 32'h1234_5678, 0, '0, 0);
    // 150 bytes overflow the buffer and would wrap to a 22-byte sgap if kept
    add_test("overflow", MSG_W'({rec_a.sn, LCMD_SGAP, DEV_NAME, 32'h0BAD_CAFE, {106{8'h5A}},
                                 rec_a.sn, LCMD_SGAP, DEV_NAME, 32'h0BAD_CAFE}),
             150, 0, rec_a, 1, 32'h1234_5678, 0, '0, 0);
    add_test("sgap_gapped", MSG_W'({rec_a.sn, LCMD_SGAP, DEV_NAME, 32'hCAFE_F00D}), 22, 1,
             rec_a, 1, 32'hCAFE_F00D, 0, '0, 0);
  endtask

  // --------------------------------------------------------------------------
  // stream driver and per-test sequence
  // --------------------------------------------------------------------------
  task automatic send_message(input int idx);
    int                          pos;
    int                          n;
    int                          i;
    bit                          ready_now;
    logic [`F9MG_DATA_WIDTH-1:0] d;
    logic [`F9MG_KEEP_WIDTH-1:0] k;
    pos = 0;
    while (pos < msg_len[idx]) begin
      n = msg_len[idx] - pos;
      if (n > `F9MG_KEEP_WIDTH) begin
        n = `F9MG_KEEP_WIDTH;
      end
      d = '0;
      k = '0;
      for (i = 0; i < n; i++) begin
        d[i*8 +: 8] = msg_data[idx][MSG_W - 8 - (pos + i) * 8 +: 8];
        k[i]        = 1'b1;
      end
      if (msg_gaps[idx]) begin
        repeat ($urandom_range(2, 0)) begin
          @(posedge axis_clk_in);
          axis_valid_in <= 1'b0;
        end
      end
      // a beat with ready low is offered again on the next cycle
      ready_now = 1'b0;
      while (!ready_now) begin
        @(posedge axis_clk_in);
        ready_now = msg_gaps[idx] ? ($urandom_range(3, 0) != 0) : 1'b1;
        axis_valid_in <= 1'b1;
        axis_data_in  <= d;
        axis_keep_in  <= k;
        axis_last_in  <= (pos + n >= msg_len[idx]);
        axis_ready_in <= ready_now;
      end
      pos += n;
    end
    @(posedge axis_clk_in);
    axis_valid_in <= 1'b0;
    axis_last_in  <= 1'b0;
    axis_keep_in  <= '0;
    axis_ready_in <= 1'b1;
  endtask

  task automatic drain_queue();
    while (pending.size() != 0) begin
      @(negedge axis_clk_in);
      check_flag("rcvr_valid", 1'b1, rcvr_valid);
      check_rcvr(pending[0], rcvr_data);
      @(posedge axis_clk_in);
      rcvr_pop <= 1'b1;
      @(posedge axis_clk_in);
      rcvr_pop <= 1'b0;
      void'(pending.pop_front());
    end
    @(negedge axis_clk_in);
    check_flag("rcvr_valid", 1'b0, rcvr_valid);
  endtask

  task automatic run_test(input int idx);
    int errs_before;
    errs_before = err_count;
    send_message(idx);
    repeat (SETTLE) @(posedge axis_clk_in);
    @(negedge axis_clk_in);
    if (exp_push[idx]) begin
      pending.push_back(exp_req[idx]);
    end
    check_rec(exp_rec[idx], sn_rec);
    check_flag("f9pcap_en", exp_en[idx], f9pcap_en);
    check_gap(exp_gap[idx], sgap);
    check_flag("rcvr_valid", pending.size() != 0, rcvr_valid);
    if (pending.size() != 0) begin
      check_rcvr(pending[0], rcvr_data);
    end
    if (drain[idx]) begin
      drain_queue();
    end
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", idx, test_name[idx]);
    end else begin
      $display("test %0d %s: %0d mismatches", idx, test_name[idx], err_count - errs_before);
      fail_tests++;
    end
  endtask

  initial begin
    void'($urandom(78350));
    axis_rst_in   = 1'b1;
    axis_valid_in = 1'b0;
    axis_ready_in = 1'b1;
    axis_data_in  = '0;
    axis_keep_in  = '0;
    axis_last_in  = 1'b0;
    rcvr_pop      = 1'b0;
    err_count     = 0;
    fail_tests    = 0;
    num_filled    = 0;
    build_table();
    repeat (3) @(posedge axis_clk_in);
    axis_rst_in <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
             NUM_TESTS, NUM_TESTS - fail_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* f9mg_cmd_top.sv */
`include "f9mg_params.svh"

module f9mg_cmd_top (
  input  logic                         axis_clk_in,
  input  logic                         axis_rst_in,
  input  logic                         axis_valid_in,
  input  logic                         axis_ready_in,
  input  logic [`F9MG_DATA_WIDTH-1:0]  axis_data_in,
  input  logic [`F9MG_KEEP_WIDTH-1:0]  axis_keep_in,
  input  logic                         axis_last_in,
  input  logic                         rcvr_pop,
  output logic                         f9pcap_en,
  output f9mg_pkg::sn_record_t         sn_rec,
  output logic [`F9MG_SGAP_WIDTH-1:0]  sgap,
  output logic                         rcvr_valid,
  output f9mg_pkg::rcvr_req_t          rcvr_data
);

  import f9mg_pkg::*;

  cmd_frame_t frame;
  logic       rcvr_push;
  rcvr_req_t  rcvr_push_data;

  // --------------------------------------------------------------------------
  // message assembly
  // --------------------------------------------------------------------------
  f9mg_cmd_buffer f9mg_cmd_buffer_i (
    .axis_clk_in   (axis_clk_in),
    .axis_rst_in   (axis_rst_in),
    .axis_valid_in (axis_valid_in),
    .axis_ready_in (axis_ready_in),
    .axis_data_in  (axis_data_in),
    .axis_keep_in  (axis_keep_in),
    .axis_last_in  (axis_last_in),
    .frame         (frame)
  );

  // --------------------------------------------------------------------------
  // global and local decoders
  // --------------------------------------------------------------------------
  f9mg_resn_store f9mg_resn_store_i (
    .axis_clk_in (axis_clk_in),
    .axis_rst_in (axis_rst_in),
    .frame       (frame),
    .sn_rec      (sn_rec),
    .f9pcap_en   (f9pcap_en)
  );

  // local commands are addressed by the stored serial number
  f9mg_local_cmd f9mg_local_cmd_i (
    .axis_clk_in (axis_clk_in),
    .axis_rst_in (axis_rst_in),
    .frame       (frame),
    .dev_sn      (sn_rec.sn),
    .sgap        (sgap),
    .rcvr_push   (rcvr_push),
    .rcvr_data   (rcvr_push_data)
  );

  f9mg_recover_fifo f9mg_recover_fifo_i (
    .axis_clk_in (axis_clk_in),
    .axis_rst_in (axis_rst_in),
    .push        (rcvr_push),
    .push_data   (rcvr_push_data),
    .pop         (rcvr_pop),
    .valid       (rcvr_valid),
    .data        (rcvr_data)
  );

endmodule

/* f9mg_recover_fifo.sv */
`include "f9mg_params.svh"

module f9mg_recover_fifo (
  input  logic                axis_clk_in,
  input  logic                axis_rst_in,
  input  logic                push,
  input  f9mg_pkg::rcvr_req_t push_data,
  input  logic                pop,
  output logic                valid,
  output f9mg_pkg::rcvr_req_t data
);

  import f9mg_pkg::*;

  localparam int DEPTH = `F9MG_RCVR_DEPTH;
  localparam int PTR_W = `F9MG_RCVR_PTR_WIDTH;
  localparam int CNT_W = PTR_W + 1;

  rcvr_req_t         mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  // full drops the push, empty ignores the pop
  assign do_push = push && (count != CNT_W'(DEPTH));
  assign do_pop  = pop && valid;

  // --------------------------------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------------------------------
  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge axis_clk_in) begin
    if (axis_rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge axis_clk_in) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // first-word fall-through head
  assign valid = (count != '0);
  assign data  = mem[rd_ptr];

  count_bound_a : assert property (@(posedge axis_clk_in) disable iff (axis_rst_in)
    count <= CNT_W'(DEPTH));

endmodule

/* f9mg_local_cmd.sv */
`include "f9mg_params.svh"

module f9mg_local_cmd (
  input  logic                                        axis_clk_in,
  input  logic                                        axis_rst_in,
  input  f9mg_pkg::cmd_frame_t                        frame,
  input  logic [`F9MG_SN_LENGTH*`F9MG_BYTE_WIDTH-1:0] dev_sn,
  output logic [`F9MG_SGAP_WIDTH-1:0]                 sgap,
  output logic                                        rcvr_push,
  output f9mg_pkg::rcvr_req_t                         rcvr_data
);

  import f9mg_pkg::*;

  localparam int LEN_W    = `F9MG_LEN_WIDTH;
  localparam int HDR_LEN  = `F9MG_CMD_LENGTH + `F9MG_NAME_LENGTH;
  localparam int ARGS_W   = `F9MG_ARG_MAX_LENGTH * `F9MG_BYTE_WIDTH;
  localparam int HEAD_W   = `F9MG_RCVR_LENGTH * `F9MG_BYTE_WIDTH;
  localparam int LCMD_W   = `F9MG_LCMD_LENGTH * `F9MG_BYTE_WIDTH;
  localparam int SGAP_LEN = `F9MG_SGAP_WIDTH / `F9MG_BYTE_WIDTH;

  logic              stg_valid;
  logic [LCMD_W-1:0] stg_lcmd;
  logic [LEN_W-1:0]  stg_arg_len;
  logic [HEAD_W-1:0] stg_arg;
  logic              sgap_hit;

  // --------------------------------------------------------------------------
  // stage 1, serial number match on the local view
  // --------------------------------------------------------------------------
  always_ff @(posedge axis_clk_in) begin
    if (axis_rst_in) begin
      stg_valid <= 1'b0;
    end else begin
      stg_valid <= frame.valid && (frame.header.lcl.sn == dev_sn);
    end
  end

  // only the first eight argument bytes are ever decoded
  always_ff @(posedge axis_clk_in) begin
    if (frame.valid) begin
      stg_lcmd    <= frame.header.lcl.lcmd;
      // short frames wrap here and then match no length below
      stg_arg_len <= frame.len - LEN_W'(HDR_LEN);
      stg_arg     <= frame.args[ARGS_W-1 -: HEAD_W];
    end
  end

  // --------------------------------------------------------------------------
  // stage 2, command decode
  // --------------------------------------------------------------------------
  assign sgap_hit = stg_valid
                 && (stg_lcmd == LCMD_SGAP)
                 && (stg_arg_len == LEN_W'(SGAP_LEN));

  // first argument byte lands in the top bits of sgap
  always_ff @(posedge axis_clk_in) begin
    if (axis_rst_in) begin
      sgap <= '0;
    end else if (sgap_hit) begin
      sgap <= stg_arg[HEAD_W-1 -: `F9MG_SGAP_WIDTH];
    end
  end

  // push goes straight to the queue so the head shows one cycle later
  assign rcvr_push = stg_valid
                  && (stg_lcmd == LCMD_RCVR)
                  && (stg_arg_len == LEN_W'(`F9MG_RCVR_LENGTH));
  assign rcvr_data = rcvr_req_t'(stg_arg);

  sgap_rcvr_excl_a : assert property (@(posedge axis_clk_in) disable iff (axis_rst_in)
    rcvr_push |=> $stable(sgap));

endmodule

/* f9mg_resn_store.sv */
`include "f9mg_params.svh"

module f9mg_resn_store (
  input  logic                   axis_clk_in,
  input  logic                   axis_rst_in,
  input  f9mg_pkg::cmd_frame_t   frame,
  output f9mg_pkg::sn_record_t   sn_rec,
  output logic                   f9pcap_en
);

  import f9mg_pkg::*;

  localparam int LEN_W     = `F9MG_LEN_WIDTH;
  localparam int RESN_LEN  = `F9MG_CMD_LENGTH + `F9MG_SN_REC_LENGTH;
  localparam int ARGS_W    = `F9MG_ARG_MAX_LENGTH * `F9MG_BYTE_WIDTH;
  localparam int REC_ARG_W = (`F9MG_SN_REC_LENGTH - `F9MG_NAME_LENGTH) * `F9MG_BYTE_WIDTH;

  logic resn_hit;

  // global view of the header, and the record length must be exact
  assign resn_hit = frame.valid
                 && (frame.header.cmd == CMD_RESN)
                 && (frame.len == LEN_W'(RESN_LEN));

  // --------------------------------------------------------------------------
  // serial record
  // --------------------------------------------------------------------------
  // the record is the 32 bytes right after the command, name first
  always_ff @(posedge axis_clk_in) begin
    if (axis_rst_in) begin
      sn_rec <= '0;
    end else if (resn_hit) begin
      sn_rec <= sn_record_t'({frame.name, frame.args[ARGS_W-1 -: REC_ARG_W]});
    end
  end

  // enable follows the stored name one cycle later
  always_ff @(posedge axis_clk_in) begin
    if (axis_rst_in) begin
      f9pcap_en <= 1'b0;
    end else begin
      f9pcap_en <= (sn_rec.dev_name == DEV_NAME);
    end
  end

endmodule

/* f9mg_cmd_buffer.sv */
`include "f9mg_params.svh"

module f9mg_cmd_buffer (
  input  logic                        axis_clk_in,
  input  logic                        axis_rst_in,
  input  logic                        axis_valid_in,
  input  logic                        axis_ready_in,
  input  logic [`F9MG_DATA_WIDTH-1:0] axis_data_in,
  input  logic [`F9MG_KEEP_WIDTH-1:0] axis_keep_in,
  input  logic                        axis_last_in,
  output f9mg_pkg::cmd_frame_t        frame
);

  localparam int BUF_LEN = `F9MG_BUF_LENGTH;
  localparam int BUF_W   = BUF_LEN * `F9MG_BYTE_WIDTH;
  localparam int LEN_W   = `F9MG_LEN_WIDTH;
  localparam int SUM_W   = LEN_W + 1;
  localparam int CNT_W   = $clog2(`F9MG_KEEP_WIDTH + 1);

  logic              beat_take;
  logic [CNT_W-1:0]  beat_bytes;
  logic [SUM_W-1:0]  cnt_sum;
  logic              msg_ovf;
  logic [LEN_W-1:0]  byte_cnt;
  logic              ovf_q;
  logic              frame_valid;
  logic [LEN_W-1:0]  frame_len;
  logic [BUF_W-1:0]  buf_q;

  assign beat_take = axis_valid_in && axis_ready_in;

  // kept lanes are contiguous from lane 0 so a count gives the byte total
  always_comb begin
    beat_bytes = '0;
    for (int i = 0; i < `F9MG_KEEP_WIDTH; i++) begin
      beat_bytes = beat_bytes + CNT_W'(axis_keep_in[i]);
    end
  end

  assign cnt_sum = SUM_W'(byte_cnt) + SUM_W'(beat_bytes);
  assign msg_ovf = ovf_q || (cnt_sum > SUM_W'(BUF_LEN));

  // --------------------------------------------------------------------------
  // byte count and frame strobe
  // --------------------------------------------------------------------------
  always_ff @(posedge axis_clk_in) begin
    if (axis_rst_in) begin
      byte_cnt    <= '0;
      ovf_q       <= 1'b0;
      frame_valid <= 1'b0;
      frame_len   <= '0;
    end else begin
      frame_valid <= 1'b0;
      if (beat_take) begin
        if (axis_last_in) begin
          byte_cnt    <= '0;
          ovf_q       <= 1'b0;
          frame_valid <= !msg_ovf;
          if (!msg_ovf) begin
            frame_len <= cnt_sum[LEN_W-1:0];
          end
        end else if (msg_ovf) begin
          // rest of the message is thrown away
          ovf_q <= 1'b1;
        end else begin
          byte_cnt <= cnt_sum[LEN_W-1:0];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // byte placement, arrival order from the top of the buffer down
  // --------------------------------------------------------------------------
  always_ff @(posedge axis_clk_in) begin
    if (beat_take) begin
      for (int i = 0; i < `F9MG_KEEP_WIDTH; i++) begin
        if (axis_keep_in[i] && (int'(byte_cnt) + i < BUF_LEN)) begin
          buf_q[(BUF_LEN - 1 - int'(byte_cnt) - i) * `F9MG_BYTE_WIDTH +: `F9MG_BYTE_WIDTH]
            <= axis_data_in[i * `F9MG_BYTE_WIDTH +: `F9MG_BYTE_WIDTH];
        end
      end
    end
  end

  // header, name and args follow the buffer order
  assign frame = {frame_valid, frame_len, buf_q};

  keep_contiguous_a : assert property (@(posedge axis_clk_in) disable iff (axis_rst_in)
    beat_take |-> ((axis_keep_in & (axis_keep_in + 1'b1)) == '0));

endmodule

/* f9mg_pkg.sv */
`include "f9mg_params.svh"

package f9mg_pkg;

  // two views of the same 12 command bytes
  typedef struct packed {
    logic [`F9MG_SN_LENGTH*`F9MG_BYTE_WIDTH-1:0]   sn;
    logic [`F9MG_LCMD_LENGTH*`F9MG_BYTE_WIDTH-1:0] lcmd;
  } cmd_local_t;

  typedef union packed {
    logic [`F9MG_CMD_LENGTH*`F9MG_BYTE_WIDTH-1:0] cmd;
    cmd_local_t                                    lcl;
  } cmd_header_u;

  // assembled message, first received byte at the top of header
  typedef struct packed {
    logic                                              valid;
    logic [`F9MG_LEN_WIDTH-1:0]                        len;
    cmd_header_u                                       header;
    logic [`F9MG_NAME_LENGTH*`F9MG_BYTE_WIDTH-1:0]     name;
    logic [`F9MG_ARG_MAX_LENGTH*`F9MG_BYTE_WIDTH-1:0]  args;
  } cmd_frame_t;

  // serial record stored by the resn command
  typedef struct packed {
    logic [`F9MG_NAME_LENGTH*`F9MG_BYTE_WIDTH-1:0] dev_name;
    logic [`F9MG_SN_LENGTH*`F9MG_BYTE_WIDTH-1:0]   sn;
    logic [31:0]                                   mcgroup_addr;
    logic [15:0]                                   mcgroup_port;
    logic [47:0]                                   src_mac_addr;
    logic [31:0]                                   src_ip_addr;
    logic [15:0]                                   src_port;
  } sn_record_t;

  typedef logic [`F9MG_RCVR_LENGTH*`F9MG_BYTE_WIDTH-1:0] rcvr_req_t;

  // --------------------------------------------------------------------------
  // command strings
  // --------------------------------------------------------------------------
  localparam logic [`F9MG_CMD_LENGTH*`F9MG_BYTE_WIDTH-1:0] CMD_RESN = "fonwin:resn:";

  localparam logic [`F9MG_NAME_LENGTH*`F9MG_BYTE_WIDTH-1:0] DEV_NAME = "f9pcap";

  localparam logic [`F9MG_LCMD_LENGTH*`F9MG_BYTE_WIDTH-1:0] LCMD_SGAP = "sgap";
  localparam logic [`F9MG_LCMD_LENGTH*`F9MG_BYTE_WIDTH-1:0] LCMD_RCVR = "rcvr";

endpackage

/* f9mg_params.svh */
`ifndef F9MG_PARAMS_SVH
`define F9MG_PARAMS_SVH

// --------------------------------------------------------------------------
// stream and byte widths
// --------------------------------------------------------------------------
`define F9MG_BYTE_WIDTH      8
`define F9MG_DATA_WIDTH      64
`define F9MG_KEEP_WIDTH      8

// --------------------------------------------------------------------------
// command buffer layout
// --------------------------------------------------------------------------
`define F9MG_CMD_LENGTH      12
`define F9MG_NAME_LENGTH     6
`define F9MG_ARG_MAX_LENGTH  64
`define F9MG_BUF_LENGTH      82
// byte length field, holds 0 to 82
`define F9MG_LEN_WIDTH       7

// serial number and local command name share the 12 command bytes
`define F9MG_SN_LENGTH       8
`define F9MG_LCMD_LENGTH     4
`define F9MG_SN_REC_LENGTH   32

// --------------------------------------------------------------------------
// local command payloads
// --------------------------------------------------------------------------
`define F9MG_SGAP_WIDTH      32
`define F9MG_RCVR_LENGTH     8
`define F9MG_RCVR_DEPTH      16
`define F9MG_RCVR_PTR_WIDTH  4

`endif
